// ==== list.f ====
+incdir+source
source/pipe_pkg.sv
source/exe_stage.sv
source/data_sram.sv
source/mem_stage.sv
source/load_align.sv
source/wb_stage.sv
source/backend_top.sv
tests/tb_backend.sv

// ==== Makefile ====
# Verilator flow for the pipeline back end
VERILATOR ?= verilator
TOP       ?= tb_backend
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build: $(BIN)

$(BIN): $(shell cat $(FLIST) | grep -v '^+') source/pipe_consts.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_backend.sv ====
`include "pipe_consts.svh"

module tb_backend import pipe_pkg::*; ();
    localparam int          N_INSTR = 180;            // Upper bound over all phases
    localparam logic [31:0] BASE    = 32'h0000_0100;  // First of the 16 words under test

    logic    clk;
    logic    resetn;
    logic    issue_valid;
    issue_t  issue;
    logic    issue_ready;
    logic    hold;
    logic    commit_valid;
    commit_t commit;

    logic [31:0] mem_model [`PIPE_SRAM_WORDS];
    commit_t     exp_q[$];
    int          accept_q[$];
    int          cyc;
    int          errors;
    int          commits;
    int          hold_mode;                  // 0 low, 1 random, 2 high
    bit          check_latency;
    bit          saw_stall;
    logic [31:0] pc_next;

    backend_top dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .hold         (hold),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(N_INSTR * 20 * 10);
        $display("Watchdog expired, the pipeline stopped committing");
        $display("Summary: %0d commits checked, %0d errors", commits, errors);
        $display("Test failures found");
        $finish;
    end

    always @(posedge clk) begin
        #1;
        if (hold_mode == 1) hold = ($urandom_range(0, 1) == 1);
        else                hold = (hold_mode == 2);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Reset leaves the commit port empty and the issue port open
    assert property (@(posedge clk) !resetn |=> (!commit_valid && issue_ready))
        else begin
            errors = errors + 1;
            $display("Mismatch at time %0t: state after reset is not idle", $time);
        end

    assert property (@(posedge clk) disable iff (!resetn)
        (commit_valid && hold) |=> (commit_valid && $stable(commit)))
        else begin
            errors = errors + 1;
            $display("Mismatch at time %0t: commit changed while held", $time);
        end

    task automatic check_commit();
        commit_t exp;
        int      acc;
        if (exp_q.size() == 0) begin
            errors = errors + 1;
            $display("Commit with pc %h arrived when none was expected", commit.pc);
        end else begin
            exp = exp_q.pop_front();
            acc = accept_q.pop_front();
            commits = commits + 1;
            assert (commit == exp) else begin
                errors = errors + 1;
                $display("Mismatch at time %0t: got pc %h we %b rd %0d data %h, %s %h %b %0d %h",
                         $time, commit.pc, commit.rf_we, commit.rf_waddr, commit.rf_wdata,
                         "expected", exp.pc, exp.rf_we, exp.rf_waddr, exp.rf_wdata);
            end
            // The accept edge follows negedge acc and the commit shows two edges later
            if (check_latency) begin
                assert (cyc - acc == 3) else begin
                    errors = errors + 1;
                    $display("Mismatch at time %0t: pc %h latency off by %0d cycles",
                             $time, commit.pc, cyc - acc - 3);
                end
            end
        end
    endtask

    // Negedge sampling sees the values that the next rising edge will act on
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (resetn) begin
            if (issue_valid && issue_ready) accept_q.push_back(cyc);
            if (issue_valid && !issue_ready && hold) saw_stall = 1'b1;
            // With hold low the issue port takes one instruction every cycle
            if (check_latency && issue_valid) begin
                assert (issue_ready) else begin
                    errors = errors + 1;
                    $display("Mismatch at time %0t: issue_ready low while hold is low", $time);
                end
            end
            if (commit_valid && !hold) check_commit();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_op(input exe_op_e op, input logic [31:0] src1, input logic [31:0] src2,
                            input logic [31:0] imm, input logic [4:0] rd);
        commit_t     exp;
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  idx;
        addr         = src1 + imm;
        idx          = addr[9:2];
        word         = mem_model[idx];
        exp.pc       = pc_next;
        exp.rf_waddr = rd;
        exp.rf_we    = (rd != 5'd0) && !(op inside {op_st_w, op_st_h, op_st_b});
        case (op)
            op_add:   exp.rf_wdata = src1 + src2;
            op_sub:   exp.rf_wdata = src1 - src2;
            op_and:   exp.rf_wdata = src1 & src2;
            op_or:    exp.rf_wdata = src1 | src2;
            op_xor:   exp.rf_wdata = src1 ^ src2;
            op_sll:   exp.rf_wdata = src1 << src2[4:0];
            op_srl:   exp.rf_wdata = src1 >> src2[4:0];
            op_ld_w:  exp.rf_wdata = word;
            op_ld_h:  exp.rf_wdata = 32'($signed(16'(word >> (16 * addr[1]))));
            op_ld_hu: exp.rf_wdata = 32'(16'(word >> (16 * addr[1])));
            op_ld_b:  exp.rf_wdata = 32'($signed(8'(word >> (8 * addr[1:0]))));
            op_ld_bu: exp.rf_wdata = 32'(8'(word >> (8 * addr[1:0])));
            default:  exp.rf_wdata = addr;   // Stores report their address
        endcase
        if (op == op_st_w) mem_model[idx] = src2;
        if (op == op_st_h) mem_model[idx][16 * addr[1] +: 16] = src2[15:0];
        if (op == op_st_b) mem_model[idx][8 * addr[1:0] +: 8] = src2[7:0];
        exp_q.push_back(exp);
        issue       = '{pc: pc_next, op: op, src1: src1, src2: src2, imm: imm,
                        rf_we: 1'b1, rf_waddr: rd};
        pc_next     = pc_next + 32'd4;
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic issue_random_op();
        logic [4:0]  rd;
        logic [31:0] off;
        rd  = 5'($urandom_range(0, 31));
        off = 32'($urandom_range(0, 63));
        case ($urandom_range(0, 2))
            0:       issue_op(exe_op_e'(4'($urandom_range(0, 6))), $urandom, $urandom, 0, rd);
            1:       issue_op(exe_op_e'(4'($urandom_range(7, 11))), BASE, 0, off, rd);
            default: issue_op(exe_op_e'(4'($urandom_range(12, 14))), BASE, $urandom, off, rd);
        endcase
    endtask

    task automatic drain();
        hold_mode = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(30704));
        resetn = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        hold = 1'b0;
        cyc = 0;
        errors = 0;
        commits = 0;
        hold_mode = 0;
        check_latency = 1'b0;
        saw_stall = 1'b0;
        pc_next = 32'h1c00_0000;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int i = 0; i < 16; i++) issue_op(op_st_w, BASE, $urandom, 32'(4 * i), 5'd1);
        drain();

        // Back to back ALU ops with hold low must show the exact latency
        check_latency = 1'b1;
        for (int i = 0; i < 30; i++) begin
            issue_op(exe_op_e'(4'($urandom_range(0, 6))), $urandom, $urandom, 0,
                     5'($urandom_range(0, 31)));
        end
        issue_op(op_add, 32'd1, 32'd2, 0, 5'd0);
        drain();
        check_latency = 1'b0;

        for (int w = 0; w < 4; w++) begin
            issue_op(op_st_w, BASE, $urandom, 32'(4 * w), 5'd2);
            issue_op(op_ld_w, BASE, 0, 32'(4 * w), 5'd3);
            for (int h = 0; h < 2; h++) begin
                issue_op(op_st_h, BASE, $urandom, 32'(4 * w + 2 * h), 5'd2);
            end
            issue_op(op_ld_w, BASE, 0, 32'(4 * w), 5'd4);
            for (int b = 0; b < 4; b++) issue_op(op_st_b, BASE, $urandom, 32'(4 * w + b), 5'd2);
            issue_op(op_ld_w, BASE, 0, 32'(4 * w), 5'd5);
        end

        // Both signs in every lane
        issue_op(op_st_w, BASE, 32'h7f80_ff01, 32'h20, 5'd6);
        for (int k = 0; k < 4; k++) begin
            issue_op(op_ld_h, BASE, 0, 32'(32 + k), 5'd7);
            issue_op(op_ld_hu, BASE, 0, 32'(32 + k), 5'd8);
            issue_op(op_ld_b, BASE, 0, 32'(32 + k), 5'd9);
            issue_op(op_ld_bu, BASE, 0, 32'(32 + k), 5'd10);
        end
        drain();

        // A long hold fills the pipeline and then hold turns random
        hold_mode = 2;
        fork
            begin
                repeat (8) @(posedge clk);
                hold_mode = 1;
            end
        join_none
        issue_op(op_st_w, BASE, 32'h8001_c07f, 32'h3c, 5'd11);
        issue_op(op_ld_b, BASE, 0, 32'h3d, 5'd12);
        issue_op(op_ld_hu, BASE, 0, 32'h3e, 5'd13);
        for (int i = 0; i < 63; i++) issue_random_op();
        drain();

        assert (saw_stall) else begin
            errors = errors + 1;
            $display("issue_ready never fell while the full pipeline was held");
        end
        $display("Summary: %0d commits checked, %0d errors", commits, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== source/backend_top.sv ====
`include "pipe_consts.svh"

module backend_top import pipe_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    issue_valid,
    input  issue_t  issue,
    output logic    issue_ready,
    input  logic    hold,
    output logic    commit_valid,
    output commit_t commit
);
    logic                  es_to_ms_valid;
    es_to_ms_t             es_to_ms_bus;
    logic                  ms_allowin;
    sram_req_t             sram_req;
    logic [`PIPE_XLEN-1:0] sram_rdata;
    logic                  ms_to_ws_valid;
    es_to_ms_t             ms_bus;
    ms_to_ws_t             ms_to_ws_bus;
    logic                  ws_allowin;

    exe_stage u_exe (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (issue_valid),
        .in_bus     (issue),
        .allowin    (issue_ready),
        .ms_allowin (ms_allowin),
        .out_valid  (es_to_ms_valid),
        .out_bus    (es_to_ms_bus),
        .sram_req   (sram_req)
    );

    // Captures on the same edge as the memory stage register
    data_sram u_sram (
        .clk   (clk),
        .req   (sram_req),
        .rdata (sram_rdata)
    );

    mem_stage u_mem (
        .clk        (clk),
        .resetn     (resetn),
        .es_valid   (es_to_ms_valid),
        .es_bus     (es_to_ms_bus),
        .allowin    (ms_allowin),
        .ws_allowin (ws_allowin),
        .out_valid  (ms_to_ws_valid),
        .out_bus    (ms_bus)
    );

    load_align u_align (
        .ms_bus (ms_bus),
        .rdata  (sram_rdata),
        .ws_bus (ms_to_ws_bus)
    );

    wb_stage u_wb (
        .clk          (clk),
        .resetn       (resetn),
        .ms_valid     (ms_to_ws_valid),
        .ms_bus       (ms_to_ws_bus),
        .allowin      (ws_allowin),
        .hold         (hold),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// ==== source/wb_stage.sv ====
`include "pipe_consts.svh"

module wb_stage import pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      ms_valid,
    input  ms_to_ws_t ms_bus,
    output logic      allowin,
    input  logic      hold,
    output logic      commit_valid,
    output commit_t   commit
);
    logic                     ws_valid;
    logic [`PIPE_XLEN-1:0]    ws_pc;
    logic                     ws_rf_we;
    logic [`PIPE_RADDR_W-1:0] ws_rf_waddr;
    logic [`PIPE_XLEN-1:0]    ws_rf_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Valid and hold
    ////////////////////////////////////////////////////////////////////////////

    // An empty stage always accepts, a full one only drains without hold
    assign allowin = ~ws_valid | ~hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (allowin) begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && allowin) begin
            ws_pc       <= ms_bus.pc;
            ws_rf_we    <= ms_bus.rf_we && (ms_bus.rf_waddr != '0);   // r0 stays zero
            ws_rf_waddr <= ms_bus.rf_waddr;
            ws_rf_wdata <= ms_bus.rf_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Commit trace
    ////////////////////////////////////////////////////////////////////////////

    assign commit_valid    = ws_valid;
    assign commit.pc       = ws_pc;
    assign commit.rf_we    = ws_rf_we & ws_valid;
    assign commit.rf_waddr = ws_rf_waddr;
    assign commit.rf_wdata = ws_rf_wdata;

endmodule

// ==== source/load_align.sv ====
`include "pipe_consts.svh"

module load_align import pipe_pkg::*; (
    input  es_to_ms_t             ms_bus,
    input  logic [`PIPE_XLEN-1:0] rdata,
    output ms_to_ws_t             ws_bus
);
    logic [15:0]           half_val;
    logic [7:0]            byte_val;
    logic [`PIPE_XLEN-1:0] mem_result;

    // The low address bits pick the lane and word loads ignore them
    assign half_val = ms_bus.alu_result[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (ms_bus.alu_result[1:0])
            2'd0:    byte_val = rdata[7:0];
            2'd1:    byte_val = rdata[15:8];
            2'd2:    byte_val = rdata[23:16];
            default: byte_val = rdata[31:24];
        endcase
    end

    // Only ld_h and ld_b extend the sign
    always_comb begin
        case (ms_bus.load_op)
            ld_w:    mem_result = rdata;
            ld_h:    mem_result = {{(`PIPE_XLEN-16){half_val[15]}}, half_val};
            ld_hu:   mem_result = {{(`PIPE_XLEN-16){1'b0}}, half_val};
            ld_b:    mem_result = {{(`PIPE_XLEN-8){byte_val[7]}}, byte_val};
            ld_bu:   mem_result = {{(`PIPE_XLEN-8){1'b0}}, byte_val};
            default: mem_result = '0;
        endcase
    end

    assign ws_bus.pc       = ms_bus.pc;
    assign ws_bus.rf_we    = ms_bus.rf_we;
    assign ws_bus.rf_waddr = ms_bus.rf_waddr;
    assign ws_bus.rf_wdata = ms_bus.res_from_mem ? mem_result : ms_bus.alu_result;

endmodule

// ==== source/mem_stage.sv ====
`include "pipe_consts.svh"

module mem_stage import pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      es_valid,
    input  es_to_ms_t es_bus,
    output logic      allowin,
    input  logic      ws_allowin,
    output logic      out_valid,
    output es_to_ms_t out_bus
);
    logic      ms_valid;
    logic      ready_go;
    es_to_ms_t ms_bus;

    ////////////////////////////////////////////////////////////////////////////
    // Valid and allowin
    ////////////////////////////////////////////////////////////////////////////

    // SRAM data is already back by the time the item sits here
    assign ready_go  = 1'b1;
    assign allowin   = ~ms_valid | (ready_go & ws_allowin);
    assign out_valid = ms_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (allowin) begin
            ms_valid <= es_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_bus <= '0;
        end else if (es_valid && allowin) begin
            ms_bus <= es_bus;
        end
    end

    // An empty stage never asks for a register write
    always_comb begin
        out_bus       = ms_bus;
        out_bus.rf_we = ms_bus.rf_we & ms_valid;
    end

endmodule

// ==== source/data_sram.sv ====
`include "pipe_consts.svh"

module data_sram import pipe_pkg::*; (
    input  logic                  clk,
    input  sram_req_t             req,
    output logic [`PIPE_XLEN-1:0] rdata
);
    localparam int IDX_W   = $clog2(`PIPE_SRAM_WORDS);
    localparam int N_LANES = `PIPE_XLEN / 8;

    logic [`PIPE_XLEN-1:0] mem [`PIPE_SRAM_WORDS];
    logic [IDX_W-1:0]      idx;

    // The word index drops the byte offset bits
    assign idx = req.addr[IDX_W+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // Array and read register
    ////////////////////////////////////////////////////////////////////////////

    // The read register only moves on an enabled request
    // A stalled memory stage keeps seeing its load data this way
    always_ff @(posedge clk) begin
        if (req.en) begin
            rdata <= mem[idx];   // Old word on a write cycle
        end
    end

    // Each byte lane has its own write enable
    always_ff @(posedge clk) begin
        if (req.en) begin
            for (int lane = 0; lane < N_LANES; lane++) begin
                if (req.wstrb[lane]) begin
                    mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
                end
            end
        end
    end

endmodule

// ==== source/exe_stage.sv ====
`include "pipe_consts.svh"

module exe_stage import pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      in_valid,
    input  issue_t    in_bus,
    output logic      allowin,
    input  logic      ms_allowin,
    output logic      out_valid,
    output es_to_ms_t out_bus,
    output sram_req_t sram_req
);
    logic                       es_valid;
    logic                       ready_go;
    issue_t                     es_bus;
    logic [`PIPE_XLEN-1:0]      mem_addr;
    logic [`PIPE_XLEN-1:0]      alu_out;
    logic                       is_load;
    logic                       is_store;
    load_op_e                   load_op;
    logic [`PIPE_XLEN/8-1:0]    st_strb;
    logic [`PIPE_XLEN-1:0]      st_data;

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    assign ready_go  = 1'b1;    // Every op finishes in one cycle
    assign allowin   = ~es_valid | (ready_go & ms_allowin);
    assign out_valid = es_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            es_bus <= in_bus;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU and address generation
    ////////////////////////////////////////////////////////////////////////////

    assign mem_addr = es_bus.src1 + es_bus.imm;
    assign is_load  = es_bus.op inside {op_ld_w, op_ld_h, op_ld_hu, op_ld_b, op_ld_bu};
    assign is_store = es_bus.op inside {op_st_w, op_st_h, op_st_b};

    always_comb begin
        case (es_bus.op)
            op_add:  alu_out = es_bus.src1 + es_bus.src2;
            op_sub:  alu_out = es_bus.src1 - es_bus.src2;
            op_and:  alu_out = es_bus.src1 & es_bus.src2;
            op_or:   alu_out = es_bus.src1 | es_bus.src2;
            op_xor:  alu_out = es_bus.src1 ^ es_bus.src2;
            op_sll:  alu_out = es_bus.src1 << es_bus.src2[4:0];
            op_srl:  alu_out = es_bus.src1 >> es_bus.src2[4:0];
            default: alu_out = mem_addr;   // Loads and stores pass the address on
        endcase
    end

    always_comb begin
        case (es_bus.op)
            op_ld_w:  load_op = ld_w;
            op_ld_h:  load_op = ld_h;
            op_ld_hu: load_op = ld_hu;
            op_ld_b:  load_op = ld_b;
            op_ld_bu: load_op = ld_bu;
            default:  load_op = ld_none;
        endcase
    end

    // Store data is replicated so the addressed lane always holds it
    always_comb begin
        case (es_bus.op)
            op_st_w: begin
                st_data = es_bus.src2;
                st_strb = 4'b1111;
            end
            op_st_h: begin
                st_data = {2{es_bus.src2[15:0]}};
                st_strb = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            op_st_b: begin
                st_data = {4{es_bus.src2[7:0]}};
                st_strb = 4'b0001 << mem_addr[1:0];
            end
            default: begin
                st_data = '0;
                st_strb = '0;
            end
        endcase
    end

    // The request fires on the same edge that moves the item into memory
    assign sram_req.en    = es_valid & ready_go & ms_allowin & (is_load | is_store);
    assign sram_req.wstrb = st_strb;
    assign sram_req.addr  = mem_addr;
    assign sram_req.wdata = st_data;

    assign out_bus.pc           = es_bus.pc;
    assign out_bus.res_from_mem = is_load;
    assign out_bus.rf_we        = es_bus.rf_we & ~is_store;   // Stores never write back
    assign out_bus.rf_waddr     = es_bus.rf_waddr;
    assign out_bus.alu_result   = alu_out;
    assign out_bus.load_op      = load_op;

endmodule

// ==== source/pipe_pkg.sv ====
`include "pipe_consts.svh"

package pipe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes seen by the execute stage
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_ld_w  = 4'd7,
        op_ld_h  = 4'd8,
        op_ld_hu = 4'd9,
        op_ld_b  = 4'd10,
        op_ld_bu = 4'd11,
        op_st_w  = 4'd12,
        op_st_h  = 4'd13,
        op_st_b  = 4'd14
    } exe_op_e;

    // Load size and extension, carried into the memory stage
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_w    = 3'd1,
        ld_h    = 3'd2,
        ld_hu   = 3'd3,
        ld_b    = 3'd4,
        ld_bu   = 3'd5
    } load_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Buses between stages
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        exe_op_e                  op;
        logic [`PIPE_XLEN-1:0]    src1;
        logic [`PIPE_XLEN-1:0]    src2;     // Also the store data
        logic [`PIPE_XLEN-1:0]    imm;      // Address offset for loads and stores
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
    } issue_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     res_from_mem;
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
        logic [`PIPE_XLEN-1:0]    alu_result;   // Holds the address for memory ops
        load_op_e                 load_op;
    } es_to_ms_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
        logic [`PIPE_XLEN-1:0]    rf_wdata;
    } ms_to_ws_t;

    typedef struct packed {
        logic [`PIPE_XLEN-1:0]    pc;
        logic                     rf_we;
        logic [`PIPE_RADDR_W-1:0] rf_waddr;
        logic [`PIPE_XLEN-1:0]    rf_wdata;
    } commit_t;

    typedef struct packed {
        logic                     en;
        logic [`PIPE_XLEN/8-1:0]  wstrb;    // Zero on a read
        logic [`PIPE_XLEN-1:0]    addr;
        logic [`PIPE_XLEN-1:0]    wdata;
    } sram_req_t;

endpackage

// ==== source/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths shared by the back end stages and the data memory
////////////////////////////////////////////////////////////////////////////

// One machine word that holds data, addresses and the pc
`define PIPE_XLEN 32

// Architectural register index
// Register r0 is never written
`define PIPE_RADDR_W 5

// Depth of the data SRAM in words
// The word index is taken from the address just above the byte offset
`define PIPE_SRAM_WORDS 256

`endif
